/* all.f */
common/vlane_pkg.sv
common/vlane_if.sv
verilog/lane_dispatch.sv
lane/varith_unit.sv
lane/vmul_unit.sv
lane/vdiv_unit.sv
verilog/lane_writeback.sv
verilog/vector_lane.sv
tb/tb_vector_lane.sv

/* common/vlane_if.sv */
// dispatch to unit bus; one start strobe at a time, operands stable until the next accept
interface vlane_if;

  // operation payload, held by dispatch between accepts
  vlane_pkg::word_t opa;
  vlane_pkg::word_t opb;
  vlane_pkg::vop_t  op;

  // one-cycle unit starts, mutually exclusive
  logic start_arith;
  logic start_mul;
  logic start_div;

  // dispatch side drives everything
  modport dispatch (
    output opa,
    output opb,
    output op,
    output start_arith,
    output start_mul,
    output start_div
  );

  // units only read
  modport unit (
    input opa,
    input opb,
    input op,
    input start_arith,
    input start_mul,
    input start_div
  );

endinterface

/* common/vlane_pkg.sv */
// lane types only; 32-bit elements, three units, opcode values are not a RISC-V encoding
package vlane_pkg;

  localparam int FU_W      = 2;   // unit select width on the issue port
  localparam int OP_W      = 4;   // opcode width within a unit
  localparam int DIV_STEPS = 32;  // one quotient bit per step

  typedef logic [31:0] word_t;  // element operand and result

  // target unit of an issued operation
  typedef enum logic [FU_W-1:0] {
    ARITH = 2'd0,
    MUL   = 2'd1,
    DIV   = 2'd2
  } fu_type_t;

  // opcode, decoded by whichever unit is started
  typedef enum logic [OP_W-1:0] {
    VADD = 4'd0,
    VSUB = 4'd1,
    VAND = 4'd2,
    VOR  = 4'd3,
    VXOR = 4'd4,
    VMIN = 4'd5,   // signed
    VMAX = 4'd6,   // signed
    VMUL = 4'd7,   // low word
    VDIV = 4'd8,   // signed quotient
    VREM = 4'd9    // signed remainder
  } vop_t;

  // divider FSM
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    NORM = 2'd1,   // abs values, signs
    ITER = 2'd2,   // shift-subtract steps
    FIX  = 2'd3    // sign fixup, result out
  } div_state_t;

endpackage

/* lane/varith_unit.sv */
// fixed two-cycle latency ALU, accepts a start every cycle; overflow flagged for add/sub only
module varith_unit (
  input  logic             CLK,
  input  logic             nRST,
  vlane_if.unit            vif,
  output logic             valid,
  output vlane_pkg::word_t result,
  output logic             exception
);

  vlane_pkg::word_t sum;    // add or sub, per opcode
  logic             s1_valid;
  vlane_pkg::vop_t  s1_op;
  vlane_pkg::word_t s1_a;
  vlane_pkg::word_t s1_b;
  vlane_pkg::word_t s1_sum;
  vlane_pkg::word_t s1_and;
  vlane_pkg::word_t s1_or;
  vlane_pkg::word_t s1_xor;
  logic             s1_lt;  // a < b signed

  assign sum = (vif.op == vlane_pkg::VSUB) ? vif.opa - vif.opb : vif.opa + vif.opb;

  // valid pipe
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
      valid    <= 1'b0;
    end else begin
      s1_valid <= vif.start_arith;
      valid    <= s1_valid;
    end
  end

  // stage one, raw results
  always_ff @(posedge CLK) begin
    s1_op  <= vif.op;
    s1_a   <= vif.opa;
    s1_b   <= vif.opb;
    s1_sum <= sum;
    s1_and <= vif.opa & vif.opb;
    s1_or  <= vif.opa | vif.opb;
    s1_xor <= vif.opa ^ vif.opb;
    s1_lt  <= $signed(vif.opa) < $signed(vif.opb);
  end

  // stage two, opcode select and overflow from sign bits
  always_ff @(posedge CLK) begin
    exception <= 1'b0;
    case (s1_op)
      vlane_pkg::VADD: begin
        result    <= s1_sum;
        exception <= (s1_a[31] == s1_b[31]) && (s1_sum[31] != s1_a[31]);
      end
      vlane_pkg::VSUB: begin
        result    <= s1_sum;
        exception <= (s1_a[31] != s1_b[31]) && (s1_sum[31] != s1_a[31]);
      end
      vlane_pkg::VAND: result <= s1_and;
      vlane_pkg::VOR:  result <= s1_or;
      vlane_pkg::VXOR: result <= s1_xor;
      vlane_pkg::VMIN: result <= s1_lt ? s1_a : s1_b;
      vlane_pkg::VMAX: result <= s1_lt ? s1_b : s1_a;
      default:         result <= '0;  // not an ALU op
    endcase
  end

endmodule

/* lane/vdiv_unit.sv */
// iterative signed divider, one op at a time, DIV_STEPS + 3 cycles; x/0 gives -1 or x with exception
module vdiv_unit (
  input  logic             CLK,
  input  logic             nRST,
  vlane_if.unit            vif,
  output logic             valid,
  output vlane_pkg::word_t result,
  output logic             exception,
  output logic             done
);

  typedef logic [$clog2(vlane_pkg::DIV_STEPS)-1:0] step_t;

  vlane_pkg::div_state_t state;
  step_t                 step;      // iteration count
  logic                  zero_dvs;  // divisor is zero
  vlane_pkg::word_t      quo;       // dividend in, quotient out
  vlane_pkg::word_t      rem;       // partial remainder
  vlane_pkg::word_t      dvs;       // abs divisor
  vlane_pkg::word_t      dvd_orig;  // for x/0 remainder
  logic                  neg_q;     // operand signs differ
  logic                  neg_r;     // dividend negative
  logic                  is_rem;
  logic                  div_zero;
  logic [32:0]           rem_sh;    // shifted remainder, one extra bit
  logic [32:0]           diff;      // trial subtract, msb is borrow

  assign zero_dvs = (vif.opb == '0);
  assign rem_sh   = {rem, quo[31]};
  assign diff     = rem_sh - {1'b0, dvs};
  assign done     = valid;          // done and valid are one strobe

  // FSM and step counter
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= vlane_pkg::IDLE;
      step  <= '0;
      valid <= 1'b0;
    end else begin
      valid <= 1'b0;
      case (state)
        vlane_pkg::IDLE: if (vif.start_div) state <= vlane_pkg::NORM;
        vlane_pkg::NORM: begin
          step  <= '0;
          state <= zero_dvs ? vlane_pkg::FIX : vlane_pkg::ITER;  // x/0 skips the loop
        end
        vlane_pkg::ITER: begin
          step <= step + 1'b1;
          if (step == step_t'(vlane_pkg::DIV_STEPS - 1))
            state <= vlane_pkg::FIX;
        end
        vlane_pkg::FIX: begin
          valid <= 1'b1;
          state <= vlane_pkg::IDLE;
        end
        default: state <= vlane_pkg::IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge CLK) begin
    case (state)
      vlane_pkg::NORM: begin
        neg_q    <= vif.opa[31] ^ vif.opb[31];
        neg_r    <= vif.opa[31];
        is_rem   <= (vif.op == vlane_pkg::VREM);
        div_zero <= zero_dvs;
        dvd_orig <= vif.opa;
        quo      <= vif.opa[31] ? -vif.opa : vif.opa;  // -2^31 stays 0x80000000, fine unsigned
        dvs      <= vif.opb[31] ? -vif.opb : vif.opb;
        rem      <= '0;
      end
      vlane_pkg::ITER: begin
        if (!diff[32]) begin  // fits, keep difference
          rem <= diff[31:0];
          quo <= {quo[30:0], 1'b1};
        end else begin        // restore
          rem <= rem_sh[31:0];
          quo <= {quo[30:0], 1'b0};
        end
      end
      vlane_pkg::FIX: begin
        exception <= div_zero;
        if (div_zero)
          result <= is_rem ? dvd_orig : '1;
        else if (is_rem)
          result <= neg_r ? -rem : rem;  // remainder follows dividend
        else
          result <= neg_q ? -quo : quo;  // truncates toward zero
      end
      default: ;
    endcase
  end

endmodule

/* lane/vmul_unit.sv */
// two-cycle signed multiply, low 32 bits only; no high word, never raises an exception
module vmul_unit (
  input  logic             CLK,
  input  logic             nRST,
  vlane_if.unit            vif,
  output logic             valid,
  output vlane_pkg::word_t result
);

  logic             s1_valid;  // stage one start flag
  vlane_pkg::word_t s1_a;      // registered multiplicand
  vlane_pkg::word_t s1_b;      // registered multiplier

  // valid pipe, matches the ALU depth so results stay in order
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
      valid    <= 1'b0;
    end else begin
      s1_valid <= vif.start_mul;
      valid    <= s1_valid;
    end
  end

  // stage one
  // operands registered every cycle, so a new op may start each clock
  always_ff @(posedge CLK) begin
    s1_a <= vif.opa;
    s1_b <= vif.opb;
  end

  // stage two
  // product sized to the result word, keeps the low half only
  // low half is the same for signed and unsigned operands
  always_ff @(posedge CLK) begin
    result <= $signed(s1_a) * $signed(s1_b);
  end

endmodule

/* tb/lane_input.txt */
# columns, all hex: fu_type op opa opb expected_result expected_exception
# fu_type 0 ARITH 1 MUL 2 DIV; op 0 VADD 1 VSUB 2 VAND 3 VOR 4 VXOR 5 VMIN 6 VMAX 7 VMUL 8 VDIV 9 VREM
0 0 00000005 00000007 0000000c 0
0 0 7fffffff 00000001 80000000 1
0 0 80000000 ffffffff 7fffffff 1
0 0 ffffffff 00000001 00000000 0
1 7 00000006 00000007 0000002a 0
0 1 00000010 00000003 0000000d 0
1 7 fffffffd 00000005 fffffff1 0
0 1 80000000 00000001 7fffffff 1
0 1 7fffffff ffffffff 80000000 1
0 1 00000000 00000001 ffffffff 0
1 7 fffffffc fffffff9 0000001c 0
1 7 00010000 00010000 00000000 0
0 2 f0f0a5a5 0ff05a5a 00f00000 0
0 3 f0f0a5a5 0ff05a5a fff0ffff 0
0 4 f0f0a5a5 0ff05a5a ff00ffff 0
1 7 12345678 00000010 23456780 0
2 8 00000064 00000007 0000000e 0
0 5 fffffffe 00000003 fffffffe 0
0 6 fffffffe 00000003 00000003 0
2 9 00000064 00000007 00000002 0
2 8 ffffff9c 00000007 fffffff2 0
2 9 ffffff9c 00000007 fffffffe 0
1 7 80000000 ffffffff 80000000 0
1 7 0000ffff 0000ffff fffe0001 0
2 8 00000064 fffffff9 fffffff2 0
2 9 00000064 fffffff9 00000002 0
0 5 80000000 7fffffff 80000000 0
0 6 80000000 7fffffff 7fffffff 0
2 8 ffffff9c fffffff9 0000000e 0
2 9 ffffff9c fffffff9 fffffffe 0
2 8 00001234 00000000 ffffffff 1
0 5 00000009 00000009 00000009 0
2 9 00001234 00000000 00001234 1
2 9 fffffff6 00000000 fffffff6 1
2 8 80000000 ffffffff 80000000 0
2 9 80000000 ffffffff 00000000 0
2 8 00000003 0000000a 00000000 0
2 9 7fffffff 00000010 0000000f 0
0 0 00000001 00000002 00000003 0
1 7 ffffffff ffffffff 00000001 0

/* tb/tb_vector_lane.sv */
// run from the project root for tb/lane_input.txt; first mismatch stops, DIV latency not fixed
module tb_vector_lane;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PERIOD  = 100;  // ns
  localparam int RST_CYC = 4;

  // one data line of the input file
  typedef struct {
    vlane_pkg::fu_type_t fu;
    vlane_pkg::vop_t     op;
    vlane_pkg::word_t    a;
    vlane_pkg::word_t    b;
    vlane_pkg::word_t    res;
    logic                exc;
  } line_t;

  // accepted operation, waiting for its result
  typedef struct {
    line_t line;
    int    idx;    // data line number
    time   t_acc;  // accepting edge
  } pend_t;

  logic                CLK;
  logic                nRST;
  logic                issue;
  vlane_pkg::fu_type_t fu_type;
  vlane_pkg::vop_t     op;
  vlane_pkg::word_t    opa;
  vlane_pkg::word_t    opb;
  logic                busy;
  logic                result_valid;
  vlane_pkg::word_t    result;
  logic                exception;

  line_t       lines[$];
  pend_t       pend_q[$];          // in issue order
  logic [31:0] lfsr       = 32'he9c1;
  bit          loaded     = 1'b0;
  bit          started    = 1'b0;  // first accept seen
  logic        busy_prev  = 1'b0;  // busy at the previous edge

  vector_lane vector_lane_inst (
    .CLK, .nRST, .issue, .fu_type, .op, .opa, .opb,
    .busy, .result_valid, .result, .exception
  );

  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  task automatic stop_on_error();
    $display("Checks failed");
    $fatal(1, "stopped at first error");
  endtask

  // galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // two lfsr bits, 0 to 3 idle cycles
  task automatic pick_gap(output int gap);
    logic [1:0] g;
    lfsr = lfsr_next(lfsr);
    g[0] = lfsr[0];
    lfsr = lfsr_next(lfsr);
    g[1] = lfsr[0];
    gap  = g;
  endtask

  task automatic load_lines();
    int          fd;
    int          n;
    string       text;
    logic [31:0] f, o, a, b, r, x;
    line_t       l;
    fd = $fopen("tb/lane_input.txt", "r");
    assert (fd != 0) else begin
      $display("cannot open tb/lane_input.txt for reading");
      stop_on_error();
    end
    while ($fgets(text, fd) != 0) begin
      if (text.len() < 2 || text[0] == "#")  // blank or column notes
        continue;
      n = $sscanf(text, "%h %h %h %h %h %h", f, o, a, b, r, x);
      assert (n == 6) else begin
        $display("malformed line in input file: %s", text);
        stop_on_error();
      end
      l.fu  = vlane_pkg::fu_type_t'(f[1:0]);
      l.op  = vlane_pkg::vop_t'(o[3:0]);
      l.a   = a;
      l.b   = b;
      l.res = r;
      l.exc = x[0];
      lines.push_back(l);
    end
    $fclose(fd);
  endtask

  // holds the line on the port until the lane takes it
  task automatic drive_line(input int idx);
    pend_t p;
    bit    taken;
    while (busy) @(posedge CLK);  // divider still running
    issue   <= 1'b1;
    fu_type <= lines[idx].fu;
    op      <= lines[idx].op;
    opa     <= lines[idx].a;
    opb     <= lines[idx].b;
    taken   = 1'b0;
    while (!taken) begin
      @(posedge CLK);
      taken = !busy;  // same busy the lane samples
    end
    p.line  = lines[idx];
    p.idx   = idx;
    p.t_acc = $time;
    pend_q.push_back(p);
    started = 1'b1;
  endtask

  // one extra strobe while busy, must vanish
  task automatic probe_busy();
    issue <= 1'b0;
    @(posedge CLK);
    assert (busy === 1'b1) else begin
      $display("Fail at %0d ns: busy expected 1 got %b after DIV accept", $time, busy);
      stop_on_error();
    end
    issue   <= 1'b1;
    fu_type <= vlane_pkg::ARITH;  // would give a result if taken
    op      <= vlane_pkg::VADD;
    opa     <= 32'h1;
    opb     <= 32'h1;
    @(posedge CLK);
    assert (busy === 1'b1) else begin
      $display("Fail at %0d ns: busy expected 1 got %b under the probe strobe", $time, busy);
      stop_on_error();
    end
    issue <= 1'b0;
  endtask

  task automatic check_result();
    pend_t p;
    int    lat;
    assert (pend_q.size() != 0) else begin
      $display("result_valid high at %0d ns with no operation outstanding", $time);
      stop_on_error();
    end
    if (pend_q.size() != 0) begin
      p   = pend_q.pop_front();
      lat = int'(($time - p.t_acc) / PERIOD) - 1;  // strobe rose one edge back
      assert (result === p.line.res) else begin
        $display("Fail at %0d ns: result expected %h got %h (line %0d)",
                 $time, p.line.res, result, p.idx);
        stop_on_error();
      end
      assert (exception === p.line.exc) else begin
        $display("Fail at %0d ns: exception expected %b got %b (line %0d)",
                 $time, p.line.exc, exception, p.idx);
        stop_on_error();
      end
      if (p.line.fu == vlane_pkg::DIV) begin
        assert (busy_prev === 1'b1 && busy === 1'b0) else begin
          $display("Fail at %0d ns: busy expected 1 then 0 got %b then %b (line %0d)",
                   $time, busy_prev, busy, p.idx);
          stop_on_error();
        end
      end else begin
        assert (lat == 4) else begin
          $display("Fail at %0d ns: result_valid latency expected 4 got %0d (line %0d)",
                   $time, lat, p.idx);
          stop_on_error();
        end
      end
    end
  endtask

  // output monitor, samples pre-edge values
  always @(posedge CLK) begin
    if (nRST) begin
      if (!started) begin
        assert (result_valid === 1'b0 && busy === 1'b0) else begin
          $display("Fail at %0d ns: result_valid and busy expected 0 got %b and %b",
                   $time, result_valid, busy);
          stop_on_error();
        end
      end
      if (result_valid === 1'b1)
        check_result();
      if (busy_prev === 1'b1 && busy === 1'b0) begin
        assert (result_valid === 1'b1) else begin
          $display("Fail at %0d ns: result_valid expected 1 got %b as busy fell",
                   $time, result_valid);
          stop_on_error();
        end
      end
    end
    busy_prev <= busy;
  end

  initial begin
    time limit;
    wait (loaded);
    limit = (lines.size() * (vlane_pkg::DIV_STEPS + 10) + 20) * PERIOD;
    #(limit);
    $display("watchdog expired at %0d ns, %0d results outstanding", $time, pend_q.size());
    stop_on_error();
  end

  initial begin
    int gap;
    issue   = 1'b0;
    fu_type = vlane_pkg::ARITH;
    op      = vlane_pkg::VADD;
    opa     = '0;
    opb     = '0;
    nRST    = 1'b0;
    load_lines();
    assert (lines.size() > 0) else begin
      $display("input file holds no operations");
      stop_on_error();
    end
    loaded = 1'b1;
    repeat (RST_CYC) @(posedge CLK);
    nRST <= 1'b1;
    repeat (2) @(posedge CLK);  // idle lane, outputs must stay low
    foreach (lines[i]) begin
      drive_line(i);
      if (lines[i].fu == vlane_pkg::DIV)
        probe_busy();
      pick_gap(gap);
      if (gap > 0) begin
        issue <= 1'b0;
        repeat (gap) @(posedge CLK);
      end
    end
    issue <= 1'b0;
    while (pend_q.size() != 0) @(posedge CLK);
    repeat (8) @(posedge CLK);  // room for a stray strobe
    $display("All checks passed");
    $finish;
  end

endmodule

/* verilog/lane_dispatch.sv */
// issue is a one-cycle strobe with no back-pressure; dropped while busy, busy only covers DIV
module lane_dispatch (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 issue,
  input  vlane_pkg::fu_type_t  fu_type,
  input  vlane_pkg::vop_t      op,
  input  vlane_pkg::word_t     opa,
  input  vlane_pkg::word_t     opb,
  input  logic                 div_done,
  output logic                 busy,
  vlane_if.dispatch            vif
);

  logic                accept;
  logic                acc_q;    // accepted last edge
  vlane_pkg::fu_type_t fu_q;
  vlane_pkg::vop_t     op_q;
  vlane_pkg::word_t    opa_q;
  vlane_pkg::word_t    opb_q;

  assign accept = issue & ~busy;  // strobes under busy are lost

  // control, accept flag and busy
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      acc_q <= 1'b0;
      busy  <= 1'b0;
    end else begin
      acc_q <= accept;
      if (div_done)
        busy <= 1'b0;  // falls with result_valid rising
      else if (accept && fu_type == vlane_pkg::DIV)
        busy <= 1'b1;  // high the cycle after accept
    end
  end

  // capture on accept
  always_ff @(posedge CLK) begin
    if (accept) begin
      fu_q  <= fu_type;
      op_q  <= op;
      opa_q <= opa;
      opb_q <= opb;
    end
  end

  // decoded start strobes, second register stage
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      vif.start_arith <= 1'b0;
      vif.start_mul   <= 1'b0;
      vif.start_div   <= 1'b0;
    end else begin
      vif.start_arith <= acc_q && fu_q == vlane_pkg::ARITH;
      vif.start_mul   <= acc_q && fu_q == vlane_pkg::MUL;
      vif.start_div   <= acc_q && fu_q == vlane_pkg::DIV;
    end
  end

  // payload moves with its start, held until the next one
  always_ff @(posedge CLK) begin
    if (acc_q) begin
      vif.op  <= op_q;
      vif.opa <= opa_q;
      vif.opb <= opb_q;
    end
  end

endmodule

/* verilog/lane_writeback.sv */
// at most one unit valid per cycle is assumed, no arbitration; outputs hold between strobes
module lane_writeback (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             arith_valid,
  input  vlane_pkg::word_t arith_result,
  input  logic             arith_exception,
  input  logic             mul_valid,
  input  vlane_pkg::word_t mul_result,
  input  logic             div_valid,
  input  vlane_pkg::word_t div_result,
  input  logic             div_exception,
  output logic             result_valid,
  output vlane_pkg::word_t result,
  output logic             exception
);

  logic             any_valid;
  vlane_pkg::word_t sel_result;
  logic             sel_exception;

  assign any_valid = arith_valid | mul_valid | div_valid;

  // result mux, exclusive by construction
  always_comb begin
    sel_result    = div_result;
    sel_exception = div_exception;
    if (arith_valid) begin
      sel_result    = arith_result;
      sel_exception = arith_exception;
    end else if (mul_valid) begin
      sel_result    = mul_result;
      sel_exception = 1'b0;  // multiplier never flags
    end
  end

  // lane output register
  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      result_valid <= 1'b0;
      result       <= '0;
      exception    <= 1'b0;
    end else begin
      result_valid <= any_valid;
      if (any_valid) begin  // hold otherwise
        result    <= sel_result;
        exception <= sel_exception;
      end
    end
  end

endmodule

/* verilog/vector_lane.sv */
// single lane, ARITH/MUL/DIV only; result 4 cycles after accept for ARITH/MUL, issue ignored while busy
module vector_lane (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                issue,
  input  vlane_pkg::fu_type_t fu_type,
  input  vlane_pkg::vop_t     op,
  input  vlane_pkg::word_t    opa,
  input  vlane_pkg::word_t    opb,
  output logic                busy,
  output logic                result_valid,
  output vlane_pkg::word_t    result,
  output logic                exception
);

  vlane_if lane_bus ();  // dispatch to units

  logic             arith_valid, arith_exception;
  vlane_pkg::word_t arith_result;
  logic             mul_valid;
  vlane_pkg::word_t mul_result;
  logic             div_valid, div_exception, div_done;
  vlane_pkg::word_t div_result;

  lane_dispatch dispatch_inst (
    .CLK, .nRST, .issue, .fu_type, .op, .opa, .opb,
    .div_done, .busy, .vif(lane_bus)
  );

  varith_unit arith_inst (
    .CLK, .nRST, .vif(lane_bus),
    .valid(arith_valid), .result(arith_result), .exception(arith_exception)
  );

  vmul_unit mul_inst (
    .CLK, .nRST, .vif(lane_bus),
    .valid(mul_valid), .result(mul_result)
  );

  vdiv_unit div_inst (
    .CLK, .nRST, .vif(lane_bus),
    .valid(div_valid), .result(div_result), .exception(div_exception), .done(div_done)
  );

  lane_writeback writeback_inst (
    .CLK, .nRST,
    .arith_valid, .arith_result, .arith_exception,
    .mul_valid, .mul_result,
    .div_valid, .div_result, .div_exception,
    .result_valid, .result, .exception
  );

endmodule
